//--- dv/spriteLayerTb.sv
`default_nettype none

`include "spriteLayer_defs.svh"

module spriteLayerTb;

    import spritePkg::*;

    localparam int LineCycles = 40;
    localparam int NameW = 8 * 24;

    logic                 Clk;
    logic                 arstN;
    logic                 frameTick;
    logic [`COORD_W-1:0]  pixelX;
    logic [`COORD_W-1:0]  pixelY;
    logic [`COLOR_W-1:0]  pixelColor;
    logic                 objOn;
    logic                 wbCyc;
    logic                 wbStb;
    logic                 wbWe;
    logic [`WB_ADR_W-1:0] wbAdr;
    logic [`WB_DAT_W-1:0] wbDatW;
    logic [`WB_DAT_W-1:0] wbDatR;
    logic                 wbAck;

    // Reference model of the host-visible state
    logic [`COLOR_W-1:0]  spriteModel [`SPRITE_DEPTH];
    logic [`COORD_W-1:0]  modelX;
    logic [`COORD_W-1:0]  modelY;
    logic [`COLOR_W-1:0]  modelBg;
    logic [31:0]          rngState;
    int                   cycleCount;
    int                   cycleLimit;

    spriteLayer i_spriteLayer (.*);

    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    always @(posedge Clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            stopWithFailure("Timeout, the DUT did not finish the tests in time");
        end
    end

    task automatic stopWithFailure(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic checkValue(input logic [NameW-1:0] testName, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        assert (actVal === expVal) else begin
            stopWithFailure($sformatf("ERR %0s expected %h actual %h", testName, expVal, actVal));
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ************************************************************************
    // Bus and pixel drivers entered 1 unit after a rising edge
    // ************************************************************************

    task automatic busCycle(input logic we, input logic [`WB_ADR_W-1:0] adr,
                            input logic [31:0] data, output logic [31:0] rdData);
        regWord w;
        int     adrInt;
        adrInt = int'(adr);
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = we;
        wbAdr = adr;
        wbDatW = data;
        @(posedge Clk);
        #1;
        while (!wbAck) begin
            @(posedge Clk);
            #1;
        end
        rdData = wbDatR;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        @(posedge Clk);
        #1;
        assert (!wbAck) else begin
            stopWithFailure("Bus acknowledge stayed high for more than one cycle");
        end
        w = data;
        if (we && adrInt == `REG_POS) begin
            modelX = w.pos.x;
            modelY = w.pos.y;
        end else if (we && adrInt == `REG_CTRL) begin
            modelBg = w.ctrl.bgColor;
        end else if (we && adrInt >= `SPRITE_BASE && adrInt < `SPRITE_BASE + `SPRITE_DEPTH) begin
            spriteModel[adrInt - `SPRITE_BASE] = data[`COLOR_W-1:0];
        end
    endtask

    // Stored colour 0 falls back to the background
    task automatic checkPixel(input logic [NameW-1:0] testName, input int px, input int py,
                              input logic sprite);
        logic [`COLOR_W-1:0] expColor;
        int                  idx;
        pixelX = px[`COORD_W-1:0];
        pixelY = py[`COORD_W-1:0];
        @(posedge Clk);
        #1;
        expColor = modelBg;
        if (sprite) begin
            idx = (px - int'(modelX)) + `SPRITE_W * (py - int'(modelY));
            if (spriteModel[idx] != '0) begin
                expColor = spriteModel[idx];
            end
        end
        checkValue(testName, 32'(expColor), 32'(pixelColor));
    endtask

    task automatic runLine(input logic [NameW-1:0] testName, input logic [7:0] opCode,
                           input logic [31:0] argA, input logic [31:0] argB,
                           input logic [31:0] expVal);
        logic [31:0] rdData;
        int          rx;
        int          ry;
        case (opCode)
            "W": busCycle(1'b1, `WB_ADR_W'(argA), argB, rdData);
            "R": begin
                busCycle(1'b0, `WB_ADR_W'(argA), 32'd0, rdData);
                checkValue(testName, expVal, rdData);
            end
            "T": begin
                // objOn is checked after every tick of the run
                frameTick = 1'b1;
                repeat (argA) begin
                    @(posedge Clk);
                    #1;
                    checkValue(testName, expVal, 32'(objOn));
                end
                frameTick = 1'b0;
            end
            "O": checkValue(testName, expVal, 32'(objOn));
            "P": checkPixel(testName, int'(argA), int'(argB), expVal[0]);
            "Q": repeat (argA) begin
                rngState = xorshift(rngState);
                rx = int'(rngState % `SPRITE_W);
                rngState = xorshift(rngState);
                ry = int'(rngState % `SPRITE_H);
                checkPixel(testName, int'(modelX) + rx, int'(modelY) + ry, 1'b1);
            end
            "H": for (int y = 0; y < `SPRITE_H; y++) begin
                for (int x = 0; x < `SPRITE_W; x++) begin
                    checkPixel(testName, int'(modelX) + x, int'(modelY) + y, 1'b0);
                end
            end
            "L": for (int i = 0; i < `SPRITE_DEPTH; i++) begin
                rngState = xorshift(rngState);
                busCycle(1'b1, `WB_ADR_W'(`SPRITE_BASE + i), {28'd0, rngState[3:0]}, rdData);
            end
            default: stopWithFailure("Unknown operation in the test data file");
        endcase
    endtask

    initial begin
        int                fd;
        int                rc;
        int                units;
        logic [8*128-1:0]  lineBuf;
        logic [NameW-1:0]  testName;
        logic [7:0]        opCode;
        logic [31:0]       argA;
        logic [31:0]       argB;
        logic [31:0]       expVal;
        rngState = 32'h2ac8_799d;
        cycleCount = 0;
        cycleLimit = LineCycles;
        arstN = 1'b0;
        frameTick = 1'b0;
        pixelX = '0;
        pixelY = '0;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAdr = '0;
        wbDatW = '0;
        repeat (5) @(posedge Clk);
        #1;
        arstN = 1'b1;
        fd = $fopen("dv/spriteLayerTestdata.txt", "r");
        if (fd == 0) begin
            stopWithFailure("Could not open the test data file");
        end
        while (!$feof(fd)) begin
            lineBuf = '0;
            rc = $fgets(lineBuf, fd);
            rc = $sscanf(lineBuf, "%s %s %h %h %h", testName, opCode, argA, argB, expVal);
            // Comment and blank lines do not parse to five fields
            if (rc == 5) begin
                units = (opCode == "L" || opCode == "H") ? `SPRITE_DEPTH : 1;
                cycleLimit = cycleLimit + LineCycles * units;
                runLine(testName, opCode, argA, argB, expVal);
            end
        end
        $fclose(fd);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/spriteLayerTestdata.txt
# name op a b expected, numbers in hex
# ops W write, R read, T ticks then objOn, O objOn, P pixel 1=sprite, Q random, H hidden, L load
regPosWr W 0 00640032 0
regPosRd R 0 0 00640032
regCtrlWr W 1 000000a0 0
regCtrlRd R 1 0 000000a0
unmapRd R 3 0 0
loadSprite L 0 0 0
coolArm W 1 000000a1 0
coolArmOn O 0 0 1
coolTick1 T 1 0 0
coolTick10 T 9 0 0
coolTick11 T 1 0 1
cornerTL P 32 64 1
cornerTR P 43 64 1
cornerBL P 32 77 1
cornerBR P 43 77 1
outLeft P 31 64 0
outRight P 44 64 0
outTop P 32 63 0
outBottom P 32 78 0
randIn Q c 0 0
transpWr W 200 0 0
transp P 32 64 1
hideTick T 1 0 0
hidden H 0 0 0
disarm W 1 000000a0 0
disarmOn O 0 0 0
rearm W 1 000000a1 0
rearmOn O 0 0 1

//--- files.f
+incdir+verilog
verilog/spritePkg.sv
verilog/spriteCfgIf.sv
verilog/spriteRegs.sv
verilog/enemyAttack.sv
verilog/spriteComposer.sv
verilog/spriteLayer.sv
dv/spriteLayerTb.sv

//--- run.sh
#!/bin/sh
# Build and run the sprite layer testbench with Verilator
verilator --binary --timing --assert -f files.f --top-module spriteLayerTb -o simv \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "Simulation ended without a verdict"; exit 1; }
echo "Simulation passed"

//--- verilog/enemyAttack.sv
`default_nettype none

`include "spriteLayer_defs.svh"

module enemyAttack (
    input  wire logic                       Clk,
    input  wire logic                       arstN,
    input  wire logic                       frameTick,
    input  wire logic [`COORD_W-1:0]        pixelX,
    input  wire logic [`COORD_W-1:0]        pixelY,
    spriteCfgIf.attack                      cfg,
    output logic                            isObj,
    output logic      [`SPRITE_ADDR_W-1:0]  objAddress,
    output logic                            objOn
);

    localparam int AddrW = `SPRITE_ADDR_W;
    localparam int WideW = `COORD_W + 1;
    localparam logic [`CNT_W-1:0] CoolLast = `COOLDOWN;

    logic [`CNT_W-1:0]   coolCnt;
    logic [WideW-1:0]    boxRight;
    logic [WideW-1:0]    boxBottom;
    logic [`COORD_W-1:0] offX;
    logic [`COORD_W-1:0] offY;
    logic                inX;
    logic                inY;

    // ************************************************************************
    // Cooldown counter
    // ************************************************************************

    // Parked at COOLDOWN while attack is off, so it shows right away
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            coolCnt <= '0;
        end else if (!cfg.attackReady) begin
            coolCnt <= CoolLast;
        end else if (frameTick) begin
            if (coolCnt == CoolLast) begin
                coolCnt <= '0;
            end else begin
                coolCnt <= coolCnt + 1'b1;
            end
        end
    end

    assign objOn = (coolCnt == CoolLast) && cfg.attackReady;

    // ************************************************************************
    // Hit test
    // ************************************************************************

    // One extra bit keeps the box edge from wrapping near the screen edge
    assign boxRight  = {1'b0, cfg.playerX} + WideW'(`SPRITE_W - 1);
    assign boxBottom = {1'b0, cfg.playerY} + WideW'(`SPRITE_H - 1);

    assign inX = (pixelX >= cfg.playerX) && ({1'b0, pixelX} <= boxRight);
    assign inY = (pixelY >= cfg.playerY) && ({1'b0, pixelY} <= boxBottom);

    assign offX = pixelX - cfg.playerX;
    assign offY = pixelY - cfg.playerY;

    assign isObj = inX && inY && objOn;

    always_comb begin
        objAddress = '0;
        if (isObj) begin
            objAddress = AddrW'(offX) + AddrW'(offY) * AddrW'(`SPRITE_W);
        end
    end

    addrInRange: assert property (@(posedge Clk) disable iff (!arstN)
        isObj |-> (objAddress < AddrW'(`SPRITE_DEPTH)));

endmodule

`default_nettype wire

//--- verilog/spriteCfgIf.sv
`default_nettype none

`include "spriteLayer_defs.svh"

interface spriteCfgIf;

    logic [`COORD_W-1:0]       playerX;
    logic [`COORD_W-1:0]       playerY;
    logic                      attackReady;
    logic [`COLOR_W-1:0]       bgColor;

    // Sprite memory write port
    logic                      memWe;
    logic [`SPRITE_ADDR_W-1:0] memAddr;
    logic [`COLOR_W-1:0]       memData;

    modport regs (
        output playerX, playerY, attackReady, bgColor,
        output memWe, memAddr, memData
    );

    modport attack (
        input playerX, playerY, attackReady
    );

    modport composer (
        input bgColor, memWe, memAddr, memData
    );

endinterface

`default_nettype wire

//--- verilog/spriteComposer.sv
`default_nettype none

`include "spriteLayer_defs.svh"

module spriteComposer (
    input  wire logic                       Clk,
    input  wire logic                       arstN,
    input  wire logic                       isObj,
    input  wire logic [`SPRITE_ADDR_W-1:0]  objAddress,
    spriteCfgIf.composer                    cfg,
    output logic      [`COLOR_W-1:0]        pixelColor
);

    localparam int AddrW = `SPRITE_ADDR_W;

    logic [`COLOR_W-1:0] spriteMem [`SPRITE_DEPTH];
    logic [`COLOR_W-1:0] objColor;
    logic                opaque;

    // ************************************************************************
    // Sprite bitmap
    // ************************************************************************

    always_ff @(posedge Clk) begin
        if (cfg.memWe) begin
            spriteMem[cfg.memAddr] <= cfg.memData;
        end
    end

    // Async read, the output register below gives the one cycle
    assign objColor = spriteMem[objAddress];

    // Colour 0 is see-through
    assign opaque = isObj && (objColor != '0);

    // ************************************************************************
    // Colour output
    // ************************************************************************

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            pixelColor <= '0;
        end else if (opaque) begin
            pixelColor <= objColor;
        end else begin
            pixelColor <= cfg.bgColor;
        end
    end

    // Decoder window must match the memory depth
    memWrInRange: assert property (@(posedge Clk) disable iff (!arstN)
        cfg.memWe |-> (cfg.memAddr < AddrW'(`SPRITE_DEPTH)));

endmodule

`default_nettype wire

//--- verilog/spriteLayer.sv
`default_nettype none

`include "spriteLayer_defs.svh"

module spriteLayer (
    input  wire logic                   Clk,
    input  wire logic                   arstN,
    input  wire logic                   frameTick,
    input  wire logic [`COORD_W-1:0]    pixelX,
    input  wire logic [`COORD_W-1:0]    pixelY,
    output logic      [`COLOR_W-1:0]    pixelColor,
    output logic                        objOn,
    input  wire logic                   wbCyc,
    input  wire logic                   wbStb,
    input  wire logic                   wbWe,
    input  wire logic [`WB_ADR_W-1:0]   wbAdr,
    input  wire logic [`WB_DAT_W-1:0]   wbDatW,
    output logic      [`WB_DAT_W-1:0]   wbDatR,
    output logic                        wbAck
);

    logic                      isObj;
    logic [`SPRITE_ADDR_W-1:0] objAddress;

    spriteCfgIf cfg ();

    // Decode
    spriteRegs i_spriteRegs (
        .Clk    (Clk),
        .arstN  (arstN),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbDatW (wbDatW),
        .wbDatR (wbDatR),
        .wbAck  (wbAck),
        .cfg    (cfg.regs)
    );

    // Execute
    enemyAttack i_enemyAttack (
        .Clk        (Clk),
        .arstN      (arstN),
        .frameTick  (frameTick),
        .pixelX     (pixelX),
        .pixelY     (pixelY),
        .cfg        (cfg.attack),
        .isObj      (isObj),
        .objAddress (objAddress),
        .objOn      (objOn)
    );

    // Result
    spriteComposer i_spriteComposer (
        .Clk        (Clk),
        .arstN      (arstN),
        .isObj      (isObj),
        .objAddress (objAddress),
        .cfg        (cfg.composer),
        .pixelColor (pixelColor)
    );

endmodule

`default_nettype wire

//--- verilog/spriteLayer_defs.svh
`ifndef SPRITE_LAYER_DEFS_SVH
`define SPRITE_LAYER_DEFS_SVH

// Sprite geometry in pixels
`define SPRITE_W 18
`define SPRITE_H 20
`define SPRITE_DEPTH 360
`define SPRITE_ADDR_W 9

// Cooldown cycle runs 0..COOLDOWN
`define COOLDOWN 10
`define CNT_W 5

`define COORD_W 9
`define COLOR_W 4

// Wishbone word addressing
`define WB_ADR_W 10
`define WB_DAT_W 32
`define REG_POS 0
`define REG_CTRL 1
`define SPRITE_BASE 512

`endif

//--- verilog/spritePkg.sv
`default_nettype none

`include "spriteLayer_defs.svh"

package spritePkg;

    // Position view, x in the low half and y in the high half
    typedef struct packed {
        logic [15-`COORD_W:0] padY;
        logic [`COORD_W-1:0]  y;
        logic [15-`COORD_W:0] padX;
        logic [`COORD_W-1:0]  x;
    } posView;

    // Control view
    typedef struct packed {
        logic [27-`COLOR_W:0] spare;
        logic [`COLOR_W-1:0]  bgColor;
        logic [2:0]           rsvd;
        logic                 ready;
    } ctrlView;

    typedef union packed {
        posView  pos;
        ctrlView ctrl;
    } regWord;

endpackage

`default_nettype wire

//--- verilog/spriteRegs.sv
`default_nettype none

`include "spriteLayer_defs.svh"

module spriteRegs (
    input  wire logic                   Clk,
    input  wire logic                   arstN,
    input  wire logic                   wbCyc,
    input  wire logic                   wbStb,
    input  wire logic                   wbWe,
    input  wire logic [`WB_ADR_W-1:0]   wbAdr,
    input  wire logic [`WB_DAT_W-1:0]   wbDatW,
    output logic      [`WB_DAT_W-1:0]   wbDatR,
    output logic                        wbAck,
    spriteCfgIf.regs                    cfg
);

    import spritePkg::*;

    localparam logic [`WB_ADR_W-1:0] PosAdr    = `REG_POS;
    localparam logic [`WB_ADR_W-1:0] CtrlAdr   = `REG_CTRL;
    localparam logic [`WB_ADR_W-1:0] SprBase   = `SPRITE_BASE;
    localparam logic [`WB_ADR_W-1:0] SprEnd    = `SPRITE_BASE + `SPRITE_DEPTH;

    logic                 req;
    logic                 inSprite;
    logic [`WB_ADR_W-1:0] spriteOff;
    regWord               wrWord;
    regWord               rdWord;

    // ************************************************************************
    // Bus handshake
    // ************************************************************************

    // New request only while no ack is pending
    assign req = wbCyc && wbStb && !wbAck;

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            wbAck <= 1'b0;
        end else begin
            wbAck <= req;
        end
    end

    // ************************************************************************
    // Decode
    // ************************************************************************

    assign wrWord    = wbDatW;
    assign inSprite  = (wbAdr >= SprBase) && (wbAdr < SprEnd);
    assign spriteOff = wbAdr - SprBase;

    // Memory write lands on the acknowledging edge
    assign cfg.memWe   = req && wbWe && inSprite;
    assign cfg.memAddr = spriteOff[`SPRITE_ADDR_W-1:0];
    assign cfg.memData = wbDatW[`COLOR_W-1:0];

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            cfg.playerX     <= '0;
            cfg.playerY     <= '0;
            cfg.attackReady <= 1'b0;
            cfg.bgColor     <= '0;
        end else if (req && wbWe) begin
            if (wbAdr == PosAdr) begin
                cfg.playerX <= wrWord.pos.x;
                cfg.playerY <= wrWord.pos.y;
            end else if (wbAdr == CtrlAdr) begin
                cfg.attackReady <= wrWord.ctrl.ready;
                cfg.bgColor     <= wrWord.ctrl.bgColor;
            end
        end
    end

    // Sprite window and unmapped reads give zero
    always_comb begin
        rdWord = '0;
        if (wbAdr == PosAdr) begin
            rdWord.pos.x = cfg.playerX;
            rdWord.pos.y = cfg.playerY;
        end else if (wbAdr == CtrlAdr) begin
            rdWord.ctrl.ready   = cfg.attackReady;
            rdWord.ctrl.bgColor = cfg.bgColor;
        end
    end

    always_ff @(posedge Clk) begin
        if (req) begin
            wbDatR <= rdWord;
        end
    end

    ackSingle: assert property (@(posedge Clk) disable iff (!arstN)
        wbAck |=> !wbAck);

    ackFollowsReq: assert property (@(posedge Clk) disable iff (!arstN)
        wbAck |-> $past(wbCyc && wbStb));

endmodule

`default_nettype wire
